/* audio_codec_pkg.sv */
// Register map, field widths, codec and sequencer enums, APB and frame event structs
`default_nettype none

package audio_codec_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int data_width      = 32;
    localparam int addr_width      = 8;
    localparam int frame_len_width = 16;
    localparam int count_width     = 32;
    localparam int irq_width       = 4;

    // ============================================================
    // Register byte offsets
    // ============================================================
    localparam logic [addr_width-1:0] reg_ctrl        = 8'h00;
    localparam logic [addr_width-1:0] reg_frame_len   = 8'h04;
    localparam logic [addr_width-1:0] reg_status      = 8'h08;
    localparam logic [addr_width-1:0] reg_irq_status  = 8'h0C;
    localparam logic [addr_width-1:0] reg_frame_count = 8'h10;
    localparam logic [addr_width-1:0] reg_start_count = 8'h14;

    // Control register fields
    localparam int ctrl_enable_bit     = 0;
    localparam int ctrl_start_bit      = 1;
    localparam int ctrl_soft_reset_bit = 2;
    localparam int ctrl_irq_enable_bit = 3;
    localparam int ctrl_mode_lsb       = 4;

    // Interrupt flag positions
    localparam int irq_frame_done_bit  = 0;
    localparam int irq_encode_done_bit = 1;
    localparam int irq_decode_done_bit = 2;
    localparam int irq_error_bit       = 3;

    // Status word positions
    localparam int status_idle_bit    = 0;
    localparam int status_encoder_bit = 1;
    localparam int status_decoder_bit = 2;
    localparam int status_busy_bit    = 4;
    localparam int status_error_bit   = 7;

    // ============================================================
    // Types
    // ============================================================
    typedef enum logic [1:0] {
        codec_mode_none     = 2'b00,
        codec_mode_encode   = 2'b01,
        codec_mode_decode   = 2'b10,
        codec_mode_reserved = 2'b11
    } codec_mode_e;

    typedef enum logic [1:0] {
        seq_idle  = 2'd0,
        seq_run   = 2'd1,
        seq_error = 2'd2
    } seq_state_e;

    typedef struct packed {
        logic [addr_width-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [data_width-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_width-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic                       enable;
        logic                       irq_enable;
        codec_mode_e                mode;
        logic [frame_len_width-1:0] frame_length;
    } codec_cfg_t;

    // Mode here is the one captured when the frame was started
    typedef struct packed {
        logic        done;
        logic        error;
        codec_mode_e mode;
    } frame_event_t;

endpackage

`default_nettype wire

/* apb_reg_bank.sv */
// APB slave with control and frame length registers, command pulses and read-back mux
`default_nettype none
`timescale 1ns/10ps

module apb_reg_bank import audio_codec_pkg::*; (
    input  wire  logic                   clk,
    input  wire  logic                   rst_n,
    input  wire  apb_req_t               apb_req,
    output apb_rsp_t                     apb_rsp,
    output codec_cfg_t                   cfg,
    output logic                         start,
    output logic                         soft_reset,
    output logic [irq_width-1:0]         irq_clear,
    input  wire  logic                   busy,
    input  wire  logic [irq_width-1:0]   irq_flags,
    input  wire  logic [count_width-1:0] frame_count,
    input  wire  logic [count_width-1:0] start_count
);

    logic                  access;
    logic                  wr_en;
    logic                  rd_en;
    logic [addr_width-1:0] offset;
    logic                  mapped;
    logic                  read_only;
    logic [data_width-1:0] status_word;
    logic [data_width-1:0] rdata;

    // Zero wait state access phase
    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;
    assign rd_en  = access & ~apb_req.pwrite;
    assign offset = apb_req.paddr;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        case (offset)
            reg_ctrl, reg_frame_len, reg_irq_status: read_only = 1'b0;
            reg_status, reg_frame_count, reg_start_count: read_only = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    // ============================================================
    // Configuration registers and command pulses
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg        <= '0;
            start      <= 1'b0;
            soft_reset <= 1'b0;
            irq_clear  <= '0;
        end else begin
            // Commands last exactly one cycle
            start      <= 1'b0;
            soft_reset <= 1'b0;
            irq_clear  <= '0;
            if (wr_en) begin
                case (offset)
                    reg_ctrl: begin
                        cfg.enable     <= apb_req.pwdata[ctrl_enable_bit];
                        cfg.irq_enable <= apb_req.pwdata[ctrl_irq_enable_bit];
                        cfg.mode       <= codec_mode_e'(apb_req.pwdata[ctrl_mode_lsb +: 2]);
                        start          <= apb_req.pwdata[ctrl_start_bit];
                        soft_reset     <= apb_req.pwdata[ctrl_soft_reset_bit];
                    end
                    reg_frame_len: cfg.frame_length <= apb_req.pwdata[frame_len_width-1:0];
                    reg_irq_status: irq_clear <= apb_req.pwdata[irq_width-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        status_word                     = '0;
        status_word[status_idle_bit]    = ~busy;
        status_word[status_encoder_bit] = (cfg.mode == codec_mode_encode);
        status_word[status_decoder_bit] = (cfg.mode == codec_mode_decode);
        status_word[status_busy_bit]    = busy;
        status_word[status_error_bit]   = irq_flags[irq_error_bit];
    end

    // ============================================================
    // Read-back
    // ============================================================
    always_comb begin
        rdata = '0;
        if (rd_en) begin
            case (offset)
                reg_ctrl: begin
                    // start and soft_reset always read as zero
                    rdata[ctrl_enable_bit]          = cfg.enable;
                    rdata[ctrl_irq_enable_bit]      = cfg.irq_enable;
                    rdata[ctrl_mode_lsb +: 2]       = cfg.mode;
                end
                reg_frame_len:   rdata[frame_len_width-1:0] = cfg.frame_length;
                reg_status:      rdata = status_word;
                reg_irq_status:  rdata[irq_width-1:0] = irq_flags;
                reg_frame_count: rdata = frame_count;
                reg_start_count: rdata = start_count;
                default: ;
            endcase
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & read_only));

endmodule

`default_nettype wire

/* frame_sequencer.sv */
// Frame sequencer FSM that checks a start, runs the frame and reports done or error
`default_nettype none
`timescale 1ns/10ps

module frame_sequencer import audio_codec_pkg::*; (
    input  wire  logic       clk,
    input  wire  logic       rst_n,
    input  wire  codec_cfg_t cfg,
    input  wire  logic       start,
    input  wire  logic       soft_reset,
    input  wire  logic       expired,
    output logic             timer_load,
    output logic             busy,
    output frame_event_t     frame_event
);

    seq_state_e  state;
    seq_state_e  state_next;
    codec_mode_e mode_latched;
    logic        mode_valid;
    logic        start_ok;

    assign mode_valid = (cfg.mode == codec_mode_encode) || (cfg.mode == codec_mode_decode);
    assign start_ok   = mode_valid && (cfg.frame_length != '0);

    always_comb begin
        state_next        = state;
        timer_load        = 1'b0;
        frame_event.done  = 1'b0;
        frame_event.error = 1'b0;
        frame_event.mode  = mode_latched;
        case (state)
            seq_idle: begin
                // Starts while disabled are dropped
                if (start && cfg.enable) begin
                    if (start_ok) begin
                        timer_load = 1'b1;
                        state_next = seq_run;
                    end else begin
                        state_next = seq_error;
                    end
                end
            end
            seq_run: begin
                if (expired) begin
                    frame_event.done = 1'b1;
                    state_next       = seq_idle;
                end
            end
            seq_error: begin
                frame_event.error = 1'b1;
                state_next        = seq_idle;
            end
            default: state_next = seq_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= seq_idle;
            mode_latched <= codec_mode_none;
        end else if (soft_reset) begin
            state <= seq_idle;
        end else begin
            state <= state_next;
            if (timer_load) begin
                mode_latched <= cfg.mode;
            end
        end
    end

    assign busy = (state == seq_run);

endmodule

`default_nettype wire

/* frame_timer.sv */
// Frame timer down-counter with a single expiry pulse
`default_nettype none
`timescale 1ns/10ps

module frame_timer import audio_codec_pkg::*; (
    input  wire  logic                       clk,
    input  wire  logic                       rst_n,
    input  wire  logic                       load,
    input  wire  logic [frame_len_width-1:0] frame_length,
    input  wire  logic                       soft_reset,
    output logic                             expired
);

    logic [frame_len_width-1:0] count;
    logic                       running;

    // expired goes high frame_length cycles after the load edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            running <= 1'b0;
            expired <= 1'b0;
        end else if (soft_reset) begin
            count   <= '0;
            running <= 1'b0;
            expired <= 1'b0;
        end else if (load) begin
            count   <= frame_length;
            running <= 1'b1;
            expired <= 1'b0;
        end else if (running) begin
            count <= count - 1'b1;
            if (count == 1) begin
                running <= 1'b0;
                expired <= 1'b1;
            end
        end else begin
            expired <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* event_status_unit.sv */
// Sticky interrupt flags, masked interrupt, completed frame and start counters
`default_nettype none
`timescale 1ns/10ps

module event_status_unit import audio_codec_pkg::*; (
    input  wire  logic                   clk,
    input  wire  logic                   rst_n,
    input  wire  frame_event_t           frame_event,
    input  wire  logic                   start,
    input  wire  logic                   soft_reset,
    input  wire  logic [irq_width-1:0]   irq_clear,
    input  wire  logic                   irq_enable,
    output logic [irq_width-1:0]         irq_flags,
    output logic [count_width-1:0]       frame_count,
    output logic [count_width-1:0]       start_count,
    output logic                         irq
);

    logic [irq_width-1:0] set_mask;

    always_comb begin
        set_mask = '0;
        if (frame_event.done) begin
            set_mask[irq_frame_done_bit]  = 1'b1;
            set_mask[irq_encode_done_bit] = (frame_event.mode == codec_mode_encode);
            set_mask[irq_decode_done_bit] = (frame_event.mode == codec_mode_decode);
        end
        set_mask[irq_error_bit] = frame_event.error;
    end

    // ============================================================
    // Flags and counters
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_flags <= '0;
        end else begin
            // A new event wins over a clear in the same cycle
            irq_flags <= (irq_flags & ~irq_clear) | set_mask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_count <= '0;
        end else if (soft_reset) begin
            frame_count <= '0;
        end else if (frame_event.done) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // Counts every start command, accepted or not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_count <= '0;
        end else if (start) begin
            start_count <= start_count + 1'b1;
        end
    end

    assign irq = irq_enable & (|irq_flags);

endmodule

`default_nettype wire

/* audio_codec_top.sv */
// Audio codec control top level joining register bank, sequencer, timer and status unit
`default_nettype none
`timescale 1ns/10ps

module audio_codec_top import audio_codec_pkg::*; (
    input  wire  logic     clk,
    input  wire  logic     rst_n,
    input  wire  apb_req_t apb_req,
    output apb_rsp_t       apb_rsp,
    output logic           irq
);

    codec_cfg_t             cfg;
    logic                   start;
    logic                   soft_reset;
    logic [irq_width-1:0]   irq_clear;
    logic                   timer_load;
    logic                   busy;
    frame_event_t           frame_event;
    logic                   expired;
    logic [irq_width-1:0]   irq_flags;
    logic [count_width-1:0] frame_count;
    logic [count_width-1:0] start_count;

    apb_reg_bank u_apb_reg_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .cfg         (cfg),
        .start       (start),
        .soft_reset  (soft_reset),
        .irq_clear   (irq_clear),
        .busy        (busy),
        .irq_flags   (irq_flags),
        .frame_count (frame_count),
        .start_count (start_count)
    );

    frame_sequencer u_frame_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .start       (start),
        .soft_reset  (soft_reset),
        .expired     (expired),
        .timer_load  (timer_load),
        .busy        (busy),
        .frame_event (frame_event)
    );

    frame_timer u_frame_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (timer_load),
        .frame_length (cfg.frame_length),
        .soft_reset   (soft_reset),
        .expired      (expired)
    );

    event_status_unit u_event_status_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_event (frame_event),
        .start       (start),
        .soft_reset  (soft_reset),
        .irq_clear   (irq_clear),
        .irq_enable  (cfg.irq_enable),
        .irq_flags   (irq_flags),
        .frame_count (frame_count),
        .start_count (start_count),
        .irq         (irq)
    );

endmodule

`default_nettype wire

/* audio_codec_checker.sv */
// Concurrent assertions on APB ready, interrupt masking and sequencer handshakes, with bind
`default_nettype none
`timescale 1ns/10ps

module audio_codec_checker (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic pready,
    input wire logic irq,
    input wire logic irq_enable,
    input wire logic done,
    input wire logic error,
    input wire logic timer_load,
    input wire logic busy,
    input wire logic expired
);

    int unsigned fail_count = 0;

    // Zero wait state slave
    a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin
            $error("pready dropped low");
            fail_count = fail_count + 1;
        end

    a_irq_masked: assert property (@(posedge clk) disable iff (!rst_n) irq |-> irq_enable)
        else begin
            $error("irq high while irq_enable is low");
            fail_count = fail_count + 1;
        end

    a_done_error: assert property (@(posedge clk) disable iff (!rst_n) !(done && error))
        else begin
            $error("frame done and frame error in the same cycle");
            fail_count = fail_count + 1;
        end

    // A frame only starts from idle
    a_load_idle: assert property (@(posedge clk) disable iff (!rst_n) timer_load |-> !busy)
        else begin
            $error("timer load while the sequencer is busy");
            fail_count = fail_count + 1;
        end

    a_expired_done: assert property (@(posedge clk) disable iff (!rst_n) expired |-> done)
        else begin
            $error("timer expiry without a frame done pulse");
            fail_count = fail_count + 1;
        end

endmodule

bind audio_codec_top audio_codec_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .pready     (apb_rsp.pready),
    .irq        (irq),
    .irq_enable (cfg.irq_enable),
    .done       (frame_event.done),
    .error      (frame_event.error),
    .timer_load (timer_load),
    .busy       (busy),
    .expired    (expired)
);

`default_nettype wire

/* tb_audio_codec.sv */
// Testbench with clock, reset, APB tasks, step table and checks for the audio codec control block
`default_nettype none
`timescale 1ns/10ps

module tb_audio_codec import audio_codec_pkg::*; ();

    typedef enum logic [1:0] {op_write, op_read, op_wait_irq, op_idle} step_op_e;

    // wdata is the frame length for op_wait_irq and the cycle count for op_idle
    typedef struct packed {
        step_op_e              op;
        logic [addr_width-1:0] offset;
        logic [data_width-1:0] wdata;
        logic [data_width-1:0] exp_data;
        logic                  exp_err;
        logic [3:0]            test_id;
    } step_t;

    logic     clk = 1'b0;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     irq;

    step_t    steps[$];
    int       seed = 93;
    int       cur_test = 0;
    int       test_errors = 0;
    int       total_errors = 0;
    int       tests_passed = 0;
    int       tests_failed = 0;
    int       cycles = 0;
    int       cycle_limit = 0;

    audio_codec_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq     (irq)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles without reaching the end of the table", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // ============================================================
    // APB access tasks
    // ============================================================
    task automatic apb_xfer(input logic write, input logic [addr_width-1:0] offset,
                            input logic [data_width-1:0] wdata,
                            output logic [data_width-1:0] rdata, output logic err);
        @(posedge clk);
        #1;
        apb_req.paddr   = offset;
        apb_req.pwrite  = write;
        apb_req.pwdata  = wdata;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        // prdata and pslverr are combinational in the access phase
        #2;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [addr_width-1:0] offset,
                             input logic [data_width-1:0] wdata, output logic err);
        logic [data_width-1:0] unused;
        apb_xfer(1'b1, offset, wdata, unused, err);
    endtask

    task automatic apb_read(input logic [addr_width-1:0] offset,
                            output logic [data_width-1:0] rdata, output logic err);
        apb_xfer(1'b0, offset, '0, rdata, err);
    endtask

    task automatic add_step(input step_op_e op, input logic [addr_width-1:0] offset,
                            input logic [data_width-1:0] wdata,
                            input logic [data_width-1:0] exp_data, input logic exp_err);
        step_t s;
        s.op       = op;
        s.offset   = offset;
        s.wdata    = wdata;
        s.exp_data = exp_data;
        s.exp_err  = exp_err;
        s.test_id  = cur_test[3:0];
        steps.push_back(s);
    endtask

    // ============================================================
    // Step table
    // ============================================================
    task automatic build_steps();
        int len_enc;
        int len_dec;
        len_enc = 4 + ($random(seed) & 15);
        len_dec = 4 + ($random(seed) & 15);
        cur_test = 1;
        add_step(op_read, reg_ctrl, 0, 32'h0, 1'b0);
        add_step(op_read, reg_frame_len, 0, 32'h0, 1'b0);
        add_step(op_read, reg_status, 0, 32'h01, 1'b0);
        add_step(op_read, reg_irq_status, 0, 32'h0, 1'b0);
        add_step(op_read, reg_frame_count, 0, 32'h0, 1'b0);
        add_step(op_read, reg_start_count, 0, 32'h0, 1'b0);
        add_step(op_idle, 8'h00, 1, 32'h0, 1'b0);
        // Encode with enable, start, irq_enable and mode 1
        cur_test = 2;
        add_step(op_write, reg_frame_len, len_enc, 32'h0, 1'b0);
        add_step(op_write, reg_ctrl, 32'h1B, 32'h0, 1'b0);
        add_step(op_wait_irq, 8'h00, len_enc, 32'h0, 1'b0);
        add_step(op_read, reg_irq_status, 0, 32'h3, 1'b0);
        add_step(op_read, reg_frame_count, 0, 32'h1, 1'b0);
        add_step(op_read, reg_start_count, 0, 32'h1, 1'b0);
        add_step(op_read, reg_status, 0, 32'h03, 1'b0);
        add_step(op_read, reg_ctrl, 0, 32'h19, 1'b0);
        add_step(op_read, reg_frame_len, 0, len_enc, 1'b0);
        cur_test = 3;
        add_step(op_write, reg_irq_status, 32'hF, 32'h0, 1'b0);
        add_step(op_idle, 8'h00, 2, 32'h0, 1'b0);
        add_step(op_read, reg_irq_status, 0, 32'h0, 1'b0);
        add_step(op_write, reg_frame_len, len_dec, 32'h0, 1'b0);
        add_step(op_write, reg_ctrl, 32'h2B, 32'h0, 1'b0);
        add_step(op_wait_irq, 8'h00, len_dec, 32'h0, 1'b0);
        add_step(op_read, reg_irq_status, 0, 32'h5, 1'b0);
        add_step(op_read, reg_frame_count, 0, 32'h2, 1'b0);
        add_step(op_read, reg_status, 0, 32'h05, 1'b0);
        // Start while disabled, then start with mode none
        cur_test = 4;
        add_step(op_write, reg_irq_status, 32'hF, 32'h0, 1'b0);
        add_step(op_idle, 8'h00, 2, 32'h0, 1'b0);
        add_step(op_write, reg_ctrl, 32'h1A, 32'h0, 1'b0);
        // Longer than the longest frame so a wrongly accepted start would finish
        add_step(op_idle, 8'h00, 24, 32'h0, 1'b0);
        add_step(op_read, reg_irq_status, 0, 32'h0, 1'b0);
        add_step(op_read, reg_frame_count, 0, 32'h2, 1'b0);
        add_step(op_read, reg_start_count, 0, 32'h3, 1'b0);
        add_step(op_write, reg_ctrl, 32'h0B, 32'h0, 1'b0);
        add_step(op_idle, 8'h00, 3, 32'h1, 1'b0);
        add_step(op_read, reg_irq_status, 0, 32'h8, 1'b0);
        add_step(op_read, reg_status, 0, 32'h81, 1'b0);
        add_step(op_read, reg_frame_count, 0, 32'h2, 1'b0);
        add_step(op_read, reg_start_count, 0, 32'h4, 1'b0);
        cur_test = 5;
        add_step(op_write, reg_ctrl, 32'h04, 32'h0, 1'b0);
        add_step(op_idle, 8'h00, 2, 32'h0, 1'b0);
        add_step(op_read, reg_frame_count, 0, 32'h0, 1'b0);
        add_step(op_read, reg_irq_status, 0, 32'h8, 1'b0);
        add_step(op_read, reg_start_count, 0, 32'h4, 1'b0);
        cur_test = 6;
        add_step(op_read, 8'h18, 0, 32'h0, 1'b1);
        add_step(op_write, reg_status, 32'hFF, 32'h0, 1'b1);
        add_step(op_write, reg_frame_count, 32'h55, 32'h0, 1'b1);
        add_step(op_read, reg_frame_count, 0, 32'h0, 1'b0);
        add_step(op_read, reg_start_count, 0, 32'h4, 1'b0);
    endtask

    task automatic run_step(input step_t s);
        logic [data_width-1:0] rdata;
        logic                  err;
        int                    waited;
        case (s.op)
            op_write, op_read: begin
                if (s.op == op_write) begin
                    apb_write(s.offset, s.wdata, err);
                end else begin
                    apb_read(s.offset, rdata, err);
                    assert (rdata === s.exp_data) else begin
                        $display("ERR prdata test %0d offset 0x%02h: got 0x%08h expected 0x%08h",
                                 s.test_id, s.offset, rdata, s.exp_data);
                        test_errors++;
                    end
                end
                assert (err === s.exp_err) else begin
                    $display("ERR pslverr test %0d offset 0x%02h: got 0x%0h expected 0x%0h",
                             s.test_id, s.offset, err, s.exp_err);
                    test_errors++;
                end
            end
            op_wait_irq: begin
                waited = 0;
                while (irq !== 1'b1 && waited < s.wdata + 10) begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
                assert (irq === 1'b1) else begin
                    $display("Test %0d: interrupt did not rise within %0d cycles of the start",
                             s.test_id, s.wdata + 10);
                    test_errors++;
                end
            end
            default: begin
                repeat (s.wdata) @(posedge clk);
                #1;
                assert (irq === s.exp_data[0]) else begin
                    $display("ERR irq test %0d: got 0x%0h expected 0x%0h",
                             s.test_id, irq, s.exp_data[0]);
                    test_errors++;
                end
            end
        endcase
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        apb_req = '0;
        rst_n   = 1'b0;
        build_steps();
        cycle_limit = steps.size() * 30;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (steps[i]) begin
            run_step(steps[i]);
            if (i == steps.size() - 1 || steps[i+1].test_id != steps[i].test_id) begin
                if (test_errors == 0) begin
                    $display("Test %0d passed", steps[i].test_id);
                    tests_passed++;
                end else begin
                    $display("Test %0d failed with %0d errors", steps[i].test_id, test_errors);
                    tests_failed++;
                end
                total_errors += test_errors;
                test_errors = 0;
            end
        end
        total_errors += dut.u_checker.fail_count;
        $display("Tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, total_errors, dut.u_checker.fail_count);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* audio_codec.f */
audio_codec_pkg.sv
apb_reg_bank.sv
frame_sequencer.sv
frame_timer.sv
event_status_unit.sv
audio_codec_top.sv
audio_codec_checker.sv
tb_audio_codec.sv

/* Bender.yml */
package:
  name: audio_codec

sources:
  - files:
      - audio_codec_pkg.sv
      - apb_reg_bank.sv
      - frame_sequencer.sv
      - frame_timer.sv
      - event_status_unit.sv
      - audio_codec_top.sv
  - target: test
    files:
      - audio_codec_checker.sv
      - tb_audio_codec.sv
